/* design/dcache_pkg.sv */
package dcache_pkg;

  // sizes
  localparam int addr_w    = 32;
  localparam int data_w    = 32;
  localparam int strb_w    = 4;
  localparam int index_w   = 4;
  localparam int num_lines = 16;
  // address bits 31..6, index in 5..2, byte offset in 1..0
  localparam int tag_w     = 26;

  typedef enum logic {
    op_read,
    op_write
  } cpu_op_e;

  typedef enum logic [1:0] {
    acc_hit,
    acc_clean_miss,
    acc_dirty_miss
  } access_kind_e;

  typedef enum logic [2:0] {
    ms_idle,
    ms_wb_addr,
    ms_wb_resp,
    ms_fill_addr,
    ms_fill_data,
    ms_done
  } miss_state_e;

  // one cpu word access
  typedef struct packed {
    cpu_op_e             op;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   wdata;
    logic [strb_w-1:0]   strb;
  } cpu_req_t;

  // result of the combinational tag lookup
  typedef struct packed {
    logic                hit;
    logic                dirty;
    logic [data_w-1:0]   line_data;
    logic [addr_w-1:0]   victim_addr;
  } lookup_t;

  // write command into the line store
  typedef struct packed {
    logic                en;
    logic                fill;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   data;
    logic [strb_w-1:0]   strb;
    logic                set_dirty;
  } store_wr_t;

endpackage

/* design/dcache_line_store.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_line_store (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [dcache_pkg::addr_w-1:0]    lookup_addr,
  input  dcache_pkg::store_wr_t            wr,
  output dcache_pkg::lookup_t              lookup
);

  logic [dcache_pkg::tag_w-1:0]   tag_mem  [dcache_pkg::num_lines];
  logic [dcache_pkg::data_w-1:0]  data_mem [dcache_pkg::num_lines];
  logic [dcache_pkg::num_lines-1:0] valid;
  logic [dcache_pkg::num_lines-1:0] dirty;

  logic [dcache_pkg::index_w-1:0] rd_idx;
  logic [dcache_pkg::tag_w-1:0]   rd_tag;
  logic [dcache_pkg::index_w-1:0] wr_idx;
  logic [dcache_pkg::tag_w-1:0]   wr_tag;

  assign rd_idx = lookup_addr[dcache_pkg::index_w+1:2];
  assign rd_tag = lookup_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
  assign wr_idx = wr.addr[dcache_pkg::index_w+1:2];
  assign wr_tag = wr.addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];

  // tag compare and victim address
  always_comb begin
    lookup.hit         = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    lookup.dirty       = valid[rd_idx] && dirty[rd_idx];
    lookup.line_data   = data_mem[rd_idx];
    lookup.victim_addr = {tag_mem[rd_idx], rd_idx, 2'b00};
  end

  // line status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (wr.en) begin
      valid[wr_idx] <= 1'b1;
      dirty[wr_idx] <= wr.set_dirty;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (wr.en) begin
      tag_mem[wr_idx] <= wr_tag;
      if (wr.fill) begin
        data_mem[wr_idx] <= wr.data;
      end else begin
        for (int b = 0; b < dcache_pkg::strb_w; b++) begin
          if (wr.strb[b]) begin
            data_mem[wr_idx][8*b +: 8] <= wr.data[8*b +: 8];
          end
        end
      end
    end
  end

  // a fill from memory always leaves the line clean
  a_fill_clean : assert property (
    @(posedge clk) disable iff (reset)
    wr.en |-> !(wr.fill && wr.set_dirty)
  );

endmodule

`default_nettype wire

/* design/dcache_req_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_req_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req,
  input  dcache_pkg::cpu_req_t        cpu_req,
  input  dcache_pkg::lookup_t         lookup,
  input  logic                        ack,
  output dcache_pkg::cpu_req_t        cur_req,
  output logic                        start,
  output dcache_pkg::access_kind_e    kind
);

  logic req_q;
  logic ack_q;
  logic busy;
  logic classify;
  logic issued;
  logic ack_fall;
  logic capture;

  assign ack_fall = ack_q && !ack;
  // a new req can follow right behind the falling ack
  assign capture  = req && !req_q && (!busy || ack_fall);

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q    <= 1'b0;
      ack_q    <= 1'b0;
      busy     <= 1'b0;
      classify <= 1'b0;
      start    <= 1'b0;
      issued   <= 1'b0;
      kind     <= dcache_pkg::acc_hit;
    end else begin
      req_q    <= req;
      ack_q    <= ack;
      start    <= 1'b0;
      classify <= capture;
      if (capture) begin
        busy <= 1'b1;
      end else if (ack_fall) begin
        busy <= 1'b0;
      end
      if (classify) begin
        start <= 1'b1;
        if (lookup.hit) begin
          kind <= dcache_pkg::acc_hit;
        end else if (lookup.dirty) begin
          kind <= dcache_pkg::acc_dirty_miss;
        end else begin
          kind <= dcache_pkg::acc_clean_miss;
        end
      end
      // set once the first start has gone out
      if (start) begin
        issued <= 1'b1;
      end else if (ack_fall) begin
        issued <= 1'b0;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (capture) begin
      cur_req <= cpu_req;
    end
  end

  // one start per access
  a_single_start : assert property (
    @(posedge clk) disable iff (reset)
    start |-> !issued
  );

endmodule

`default_nettype wire

/* design/dcache_miss_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_miss_exec (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  dcache_pkg::access_kind_e        kind,
  input  dcache_pkg::cpu_req_t            cur_req,
  input  logic [dcache_pkg::data_w-1:0]   victim_data,
  input  logic [dcache_pkg::addr_w-1:0]   victim_addr,

  // axi4 lite read channels
  output logic [dcache_pkg::addr_w-1:0]   araddr,
  output logic                            arvalid,
  input  logic                            arready,
  input  logic [dcache_pkg::data_w-1:0]   rdata_m,
  input  logic                            rvalid,
  output logic                            rready,

  // axi4 lite write channels
  output logic [dcache_pkg::addr_w-1:0]   awaddr,
  output logic                            awvalid,
  input  logic                            awready,
  output logic [dcache_pkg::data_w-1:0]   wdata,
  output logic [dcache_pkg::strb_w-1:0]   wstrb,
  output logic                            wvalid,
  input  logic                            wready,
  input  logic                            bvalid,
  output logic                            bready,

  output dcache_pkg::store_wr_t           fill_wr,
  output logic                            done
);

  dcache_pkg::miss_state_e state;

  logic [dcache_pkg::addr_w-1:0] fill_addr;
  logic aw_left;
  logic w_left;
  logic r_xfer;

  assign fill_addr = {cur_req.addr[dcache_pkg::addr_w-1:2], 2'b00};
  assign aw_left   = awvalid && !awready;
  assign w_left    = wvalid && !wready;
  assign r_xfer    = (state == dcache_pkg::ms_fill_data) && rvalid && rready;
  assign done      = (state == dcache_pkg::ms_done);

  // returned word goes straight into the line, clean
  always_comb begin
    fill_wr.en        = r_xfer;
    fill_wr.fill      = 1'b1;
    fill_wr.addr      = fill_addr;
    fill_wr.data      = rdata_m;
    fill_wr.strb      = '1;
    fill_wr.set_dirty = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= dcache_pkg::ms_idle;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      case (state)
        dcache_pkg::ms_idle: begin
          if (start && kind == dcache_pkg::acc_dirty_miss) begin
            // aw and w go out together
            awaddr  <= victim_addr;
            wdata   <= victim_data;
            wstrb   <= '1;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= dcache_pkg::ms_wb_addr;
          end else if (start && kind == dcache_pkg::acc_clean_miss) begin
            araddr  <= fill_addr;
            arvalid <= 1'b1;
            state   <= dcache_pkg::ms_fill_addr;
          end
        end
        dcache_pkg::ms_wb_addr: begin
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (!aw_left && !w_left) begin
            bready <= 1'b1;
            state  <= dcache_pkg::ms_wb_resp;
          end
        end
        dcache_pkg::ms_wb_resp: begin
          if (bvalid) begin
            bready  <= 1'b0;
            araddr  <= fill_addr;
            arvalid <= 1'b1;
            state   <= dcache_pkg::ms_fill_addr;
          end
        end
        dcache_pkg::ms_fill_addr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= dcache_pkg::ms_fill_data;
          end
        end
        dcache_pkg::ms_fill_data: begin
          if (rvalid) begin
            rready <= 1'b0;
            state  <= dcache_pkg::ms_done;
          end
        end
        dcache_pkg::ms_done: begin
          state <= dcache_pkg::ms_idle;
        end
        default: begin
          state <= dcache_pkg::ms_idle;
        end
      endcase
    end
  end

  // valid must wait for its ready
  a_ar_hold : assert property (
    @(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid
  );

  a_aw_hold : assert property (
    @(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid
  );

endmodule

`default_nettype wire

/* design/dcache_resp.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_resp (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req,
  input  logic                            start,
  input  dcache_pkg::access_kind_e        kind,
  input  logic                            done,
  input  dcache_pkg::cpu_req_t            cur_req,
  input  dcache_pkg::lookup_t             lookup,
  output logic                            ack,
  output logic [dcache_pkg::data_w-1:0]   rdata,
  output dcache_pkg::store_wr_t           cpu_wr
);

  logic complete;

  assign complete = (start && kind == dcache_pkg::acc_hit) || done;

  // strobed merge, marks the line dirty
  always_comb begin
    cpu_wr.en        = complete && (cur_req.op == dcache_pkg::op_write);
    cpu_wr.fill      = 1'b0;
    cpu_wr.addr      = cur_req.addr;
    cpu_wr.data      = cur_req.wdata;
    cpu_wr.strb      = cur_req.strb;
    cpu_wr.set_dirty = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (complete) begin
      ack <= 1'b1;
    end else if (ack && !req) begin
      ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (complete && cur_req.op == dcache_pkg::op_read) begin
      rdata <= lookup.line_data;
    end
  end

  a_ack_needs_req : assert property (
    @(posedge clk) disable iff (reset)
    !ack && !req |=> !ack
  );

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
  input  logic                            clk,
  input  logic                            reset,

  // cpu side
  input  logic                            req,
  input  dcache_pkg::cpu_req_t            cpu_req,
  output logic                            ack,
  output logic [dcache_pkg::data_w-1:0]   rdata,

  // memory side, axi4 lite
  output logic [dcache_pkg::addr_w-1:0]   araddr,
  output logic                            arvalid,
  input  logic                            arready,
  output logic [2:0]                      arprot,
  input  logic [dcache_pkg::data_w-1:0]   rdata_m,
  input  logic                            rvalid,
  output logic                            rready,
  output logic [dcache_pkg::addr_w-1:0]   awaddr,
  output logic                            awvalid,
  input  logic                            awready,
  output logic [2:0]                      awprot,
  output logic [dcache_pkg::data_w-1:0]   wdata,
  output logic [dcache_pkg::strb_w-1:0]   wstrb,
  output logic                            wvalid,
  input  logic                            wready,
  input  logic                            bvalid,
  output logic                            bready
);

  // unprivileged secure data access
  assign arprot = 3'b000;
  assign awprot = 3'b000;

  dcache_pkg::cpu_req_t     cur_req;
  dcache_pkg::lookup_t      lookup;
  dcache_pkg::access_kind_e kind;
  dcache_pkg::store_wr_t    fill_wr;
  dcache_pkg::store_wr_t    cpu_wr;
  dcache_pkg::store_wr_t    store_wr;
  logic                     start;
  logic                     done;

  // fill from memory wins over the cpu merge
  assign store_wr = fill_wr.en ? fill_wr : cpu_wr;

  dcache_line_store line_store_i (
    .clk,
    .reset,
    .lookup_addr (cur_req.addr),
    .wr          (store_wr),
    .lookup
  );

  dcache_req_decode req_decode_i (
    .clk,
    .reset,
    .req,
    .cpu_req,
    .lookup,
    .ack,
    .cur_req,
    .start,
    .kind
  );

  dcache_miss_exec miss_exec_i (
    .clk,
    .reset,
    .start,
    .kind,
    .cur_req,
    .victim_data (lookup.line_data),
    .victim_addr (lookup.victim_addr),
    .araddr,
    .arvalid,
    .arready,
    .rdata_m,
    .rvalid,
    .rready,
    .awaddr,
    .awvalid,
    .awready,
    .wdata,
    .wstrb,
    .wvalid,
    .wready,
    .bvalid,
    .bready,
    .fill_wr,
    .done
  );

  dcache_resp resp_i (
    .clk,
    .reset,
    .req,
    .start,
    .kind,
    .done,
    .cur_req,
    .lookup,
    .ack,
    .rdata,
    .cpu_wr
  );

endmodule

`default_nettype wire

/* sim/axi_lite_mem_model.sv */
`timescale 1ns/10ps

module axi_lite_mem_model (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] delay_rand,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata_m,
  output logic        rvalid,
  input  logic        rready,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic        bvalid,
  input  logic        bready,
  output int          ar_count,
  output int          aw_count
);

  // 256 words, 1 KiB
  logic [31:0] mem [256];
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  b_wait;
  logic        r_pend;
  logic        aw_got;
  logic        w_got;
  logic [7:0]  aw_idx;
  logic [31:0] w_data;
  logic [3:0]  w_strb;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = i * 32'h01010101 + 32'd7;
    end
    arready  = 1'b0;
    rvalid   = 1'b0;
    rdata_m  = '0;
    awready  = 1'b0;
    wready   = 1'b0;
    bvalid   = 1'b0;
    ar_count = 0;
    aw_count = 0;
  end

  // read address and read data
  always @(posedge clk) begin
    if (reset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      r_pend   <= 1'b0;
      ar_wait  <= delay_rand[1:0];
      r_wait   <= 2'd0;
      ar_count <= 0;
    end else begin
      arready <= 1'b0;
      if (arvalid && arready) begin
        ar_count <= ar_count + 1;
        rdata_m  <= mem[araddr[9:2]];
        r_pend   <= 1'b1;
        r_wait   <= delay_rand[3:2];
        ar_wait  <= delay_rand[1:0];
      end else if (arvalid && !r_pend) begin
        if (ar_wait == 2'd0) begin
          arready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 2'd1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_pend <= 1'b0;
      end else if (r_pend && !rvalid) begin
        if (r_wait == 2'd0) begin
          rvalid <= 1'b1;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  // write address, write data and response
  always @(posedge clk) begin
    if (reset) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      aw_wait  <= delay_rand[5:4];
      w_wait   <= delay_rand[7:6];
      b_wait   <= delay_rand[9:8];
      aw_count <= 0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (awvalid && awready) begin
        aw_got   <= 1'b1;
        aw_idx   <= awaddr[9:2];
        aw_count <= aw_count + 1;
        aw_wait  <= delay_rand[5:4];
      end else if (awvalid && !aw_got) begin
        if (aw_wait == 2'd0) begin
          awready <= 1'b1;
        end else begin
          aw_wait <= aw_wait - 2'd1;
        end
      end
      if (wvalid && wready) begin
        w_got  <= 1'b1;
        w_data <= wdata;
        w_strb <= wstrb;
        w_wait <= delay_rand[7:6];
      end else if (wvalid && !w_got) begin
        if (w_wait == 2'd0) begin
          wready <= 1'b1;
        end else begin
          w_wait <= w_wait - 2'd1;
        end
      end
      // both halves in, commit and respond
      if (aw_got && w_got && !bvalid) begin
        if (b_wait == 2'd0) begin
          for (int b = 0; b < 4; b++) begin
            if (w_strb[b]) begin
              mem[aw_idx][8*b +: 8] <= w_data[8*b +: 8];
            end
          end
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
          b_wait <= delay_rand[9:8];
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

endmodule

/* sim/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb;

  localparam int n_directed = 7;
  localparam int n_random   = 40;
  localparam int n_entries  = n_directed + n_random;
  localparam int max_cycles = n_entries * 200 + 20;
  localparam logic [31:0] seed = 32'hd3df6346;

  // expect_miss is 0 for a hit, 1 for a miss, 2 when only the shadow model decides
  typedef struct packed {
    dcache_pkg::cpu_op_e op;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic [3:0]          strb;
    logic [1:0]          expect_miss;
  } stim_t;

  logic clk;
  logic reset;
  logic req;
  logic ack;
  dcache_pkg::cpu_req_t cpu_req;
  logic [dcache_pkg::data_w-1:0] rdata;
  logic [dcache_pkg::addr_w-1:0] araddr;
  logic [dcache_pkg::addr_w-1:0] awaddr;
  logic [dcache_pkg::data_w-1:0] rdata_m;
  logic [dcache_pkg::data_w-1:0] wdata;
  logic [dcache_pkg::strb_w-1:0] wstrb;
  logic [2:0] arprot;
  logic [2:0] awprot;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic rready;
  logic awvalid;
  logic awready;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic bready;
  logic [31:0] delay_rand;
  int ar_count;
  int aw_count;
  int errors;
  int cycles;

  stim_t table_q [n_entries];
  logic [31:0] shadow_mem [256];
  logic [25:0] sc_tag [16];
  logic [31:0] sc_data [16];
  logic        sc_valid [16];
  logic        sc_dirty [16];

  dcache_top dut_i (
    .clk, .reset, .req, .cpu_req, .ack, .rdata,
    .araddr, .arvalid, .arready, .arprot, .rdata_m, .rvalid, .rready,
    .awaddr, .awvalid, .awready, .awprot, .wdata, .wstrb, .wvalid, .wready,
    .bvalid, .bready
  );

  axi_lite_mem_model mem_i (
    .clk, .reset, .delay_rand,
    .araddr, .arvalid, .arready, .rdata_m, .rvalid, .rready,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bvalid, .bready, .ar_count, .aw_count
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  // write-back, write-allocate, one word per line
  task automatic predict_access(input stim_t s, output logic [31:0] exp_rdata,
                                output logic exp_miss, output logic exp_wb);
    logic [3:0]  idx;
    logic [25:0] tag;
    logic [31:0] victim;
    idx = s.addr[5:2];
    tag = s.addr[31:6];
    exp_miss = !(sc_valid[idx] && sc_tag[idx] == tag);
    exp_wb = exp_miss && sc_valid[idx] && sc_dirty[idx];
    if (exp_wb) begin
      victim = {sc_tag[idx], idx, 2'b00};
      shadow_mem[victim[9:2]] = sc_data[idx];
    end
    if (exp_miss) begin
      sc_data[idx]  = shadow_mem[s.addr[9:2]];
      sc_tag[idx]   = tag;
      sc_valid[idx] = 1'b1;
      sc_dirty[idx] = 1'b0;
    end
    if (s.op == dcache_pkg::op_write) begin
      for (int b = 0; b < 4; b++) begin
        if (s.strb[b]) begin
          sc_data[idx][8*b +: 8] = s.wdata[8*b +: 8];
        end
      end
      sc_dirty[idx] = 1'b1;
    end
    exp_rdata = sc_data[idx];
  endtask

  task automatic run_entry(input stim_t s);
    logic [31:0] exp_rdata;
    logic        exp_miss;
    logic        exp_wb;
    logic        seen_miss;
    int ar_start;
    int aw_start;
    int lat;
    predict_access(s, exp_rdata, exp_miss, exp_wb);
    ar_start = ar_count;
    aw_start = aw_count;
    @(negedge clk);
    cpu_req.op    = s.op;
    cpu_req.addr  = s.addr;
    cpu_req.wdata = s.wdata;
    cpu_req.strb  = s.strb;
    req = 1'b1;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!ack);
    seen_miss = (ar_count != ar_start);
    if (s.op == dcache_pkg::op_read && rdata !== exp_rdata) begin
      report_mismatch("rdata", rdata, exp_rdata);
    end
    if (ar_count - ar_start != int'(exp_miss)) begin
      report_mismatch("ar count", ar_count - ar_start, 32'(exp_miss));
    end
    if (aw_count - aw_start != int'(exp_wb)) begin
      report_mismatch("aw count", aw_count - aw_start, 32'(exp_wb));
    end
    if (s.expect_miss != 2'd2 && seen_miss != s.expect_miss[0]) begin
      report_mismatch("miss", 32'(seen_miss), 32'(s.expect_miss[0]));
    end
    // first sampling edge is edge 0, ack is seen at the negedge after its edge
    if (!exp_miss && lat - 1 != 2) begin
      report_mismatch("ack latency", lat - 1, 2);
    end
    // plain unprivileged data accesses on both channels
    if ({arprot, awprot} !== 6'b0) begin
      report_mismatch("{arprot,awprot}", 32'({arprot, awprot}), 32'h0);
    end
    req = 1'b0;
    while (ack) begin
      @(negedge clk);
    end
    for (int i = 0; i < 256; i++) begin
      if (mem_i.mem[i] !== shadow_mem[i]) begin
        report_mismatch($sformatf("mem[%0d]", i), mem_i.mem[i], shadow_mem[i]);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    delay_rand <= xorshift32(delay_rand);
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > max_cycles) begin
      errors++;
      $display("Error at %0t: no access finished within %0d cycles", $time, max_cycles);
      $display("errors: %0d over %0d table entries", errors, n_entries);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] rng;
    logic [5:0]  idle;
    errors = 0;
    cycles = 0;
    delay_rand = seed;
    rng = seed;
    reset = 1'b1;
    req = 1'b0;
    cpu_req = '0;
    for (int i = 0; i < 256; i++) begin
      shadow_mem[i] = i * 32'h01010101 + 32'd7;
    end
    for (int i = 0; i < 16; i++) begin
      sc_valid[i] = 1'b0;
      sc_dirty[i] = 1'b0;
      sc_tag[i]   = '0;
      sc_data[i]  = '0;
    end
    // index 4 with two tags, then index 3
    table_q[0] = '{dcache_pkg::op_read,  32'h010, 32'h0,        4'b0000, 2'd1};
    table_q[1] = '{dcache_pkg::op_read,  32'h010, 32'h0,        4'b0000, 2'd0};
    table_q[2] = '{dcache_pkg::op_write, 32'h010, 32'haabbccdd, 4'b0101, 2'd0};
    table_q[3] = '{dcache_pkg::op_read,  32'h010, 32'h0,        4'b0000, 2'd0};
    table_q[4] = '{dcache_pkg::op_read,  32'h050, 32'h0,        4'b0000, 2'd1};
    table_q[5] = '{dcache_pkg::op_write, 32'h08c, 32'h11223344, 4'b1100, 2'd1};
    table_q[6] = '{dcache_pkg::op_read,  32'h08c, 32'h0,        4'b0000, 2'd0};
    // four indices, four tags each
    for (int e = n_directed; e < n_entries; e++) begin
      rng = xorshift32(rng);
      table_q[e].op          = dcache_pkg::cpu_op_e'(rng[8]);
      table_q[e].addr        = rng & 32'h0000_00cc;
      table_q[e].strb        = rng[19:16];
      table_q[e].expect_miss = 2'd2;
      rng = xorshift32(rng);
      table_q[e].wdata       = rng;
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    idle = {ack, arvalid, awvalid, wvalid, rready, bready};
    if (idle !== 6'b0) begin
      report_mismatch("{ack,arvalid,awvalid,wvalid,rready,bready}", 32'(idle), 32'h0);
    end
    for (int e = 0; e < n_entries; e++) begin
      run_entry(table_q[e]);
    end
    $display("errors: %0d over %0d table entries", errors, n_entries);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
design/dcache_pkg.sv
design/dcache_line_store.sv
design/dcache_req_decode.sv
design/dcache_miss_exec.sv
design/dcache_resp.sv
design/dcache_top.sv
sim/axi_lite_mem_model.sv
sim/dcache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module dcache_tb \
  -f filelist.f \
  -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
exit 0
